//--- design/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Source of the value written back to the register file
    typedef enum logic [2:0] {
        result_alu       = 3'b000,
        result_mem       = 3'b001,
        result_pc_target = 3'b010,
        result_pc_plus4  = 3'b011,
        result_imm_ext   = 3'b100
    } result_src_e;

    // Access width, bit 2 selects zero extension
    typedef enum logic [2:0] {
        width_32  = 3'b000,
        width_8s  = 3'b001,
        width_16s = 3'b010,
        width_8u  = 3'b101,
        width_16u = 3'b110
    } width_src_e;

    // Bundle handed over by the execute stage
    typedef struct packed {
        logic [31:0] alu_result;
        logic [31:0] write_data;
        logic [31:0] pc_target;
        logic [31:0] pc_plus4;
        logic [31:0] imm_ext;
        logic [4:0]  rd;
        width_src_e  width_src;
        result_src_e result_src;
        logic        mem_write;
        logic        reg_write;
    } ex_mem_t;

    // Bundle carried into writeback
    typedef struct packed {
        logic [31:0] reduced_data;
        logic [31:0] forward_data;
        logic [4:0]  rd;
        result_src_e result_src;
        logic        reg_write;
    } mem_wb_t;

    // One memory word, seen as byte lanes or as halfwords
    typedef union packed {
        logic [3:0][7:0]  lanes;
        logic [1:0][15:0] halves;
    } mem_word_u;

endpackage

`default_nettype wire

//--- design/load_reduce.sv
`timescale 1ns/1ns
`default_nettype none

module load_reduce import mem_pkg::*; (
    input  mem_word_u   word_i,
    input  width_src_e  width_src_i,
    input  logic [1:0]  byte_off_i,
    output logic [31:0] result_o
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // Byte picked by the full offset
    assign sel_byte = word_i.lanes[byte_off_i];

    // Halfword picked by offset bit 1, accesses are aligned
    assign sel_half = word_i.halves[byte_off_i[1]];

    always_comb begin
        case (width_src_i)
            width_8s: begin
                result_o = {{24{sel_byte[7]}}, sel_byte};
            end
            width_8u: begin
                result_o = {24'b0, sel_byte};
            end
            width_16s: begin
                result_o = {{16{sel_half[15]}}, sel_half};
            end
            width_16u: begin
                result_o = {16'b0, sel_half};
            end
            // Full word and unknown encodings pass through
            default: begin
                result_o = word_i;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/memory_stage.sv
`timescale 1ns/1ns
`default_nettype none

module memory_stage import mem_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        stall_m_i,

    // Bundle from execute
    input  ex_mem_t     ex_i,

    // Word read from the data memory
    input  mem_word_u   read_word_i,

    output ex_mem_t     mem_o,
    output logic [31:0] forward_data_m_o,
    output mem_wb_t     wb_o
);

    ex_mem_t     mem_q;
    logic [31:0] reduced_data;

    // Execute-to-memory register, held while stalled
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mem_q <= '0;
        end else if (!stall_m_i) begin
            mem_q <= ex_i;
        end
    end

    assign mem_o = mem_q;

    // Value offered to the forwarding logic
    always_comb begin
        case (mem_q.result_src)
            result_alu:       forward_data_m_o = mem_q.alu_result;
            result_pc_target: forward_data_m_o = mem_q.pc_target;
            result_pc_plus4:  forward_data_m_o = mem_q.pc_plus4;
            result_imm_ext:   forward_data_m_o = mem_q.imm_ext;
            // Load data is not ready for forwarding here
            default:          forward_data_m_o = '0;
        endcase
    end

    // Narrow the loaded word to the access width
    load_reduce load_reduce_inst (
        .word_i      (read_word_i),
        .width_src_i (mem_q.width_src),
        .byte_off_i  (mem_q.alu_result[1:0]),
        .result_o    (reduced_data)
    );

    // Pack what writeback needs
    assign wb_o = '{
        reduced_data: reduced_data,
        forward_data: forward_data_m_o,
        rd:           mem_q.rd,
        result_src:   mem_q.result_src,
        reg_write:    mem_q.reg_write
    };

endmodule

`default_nettype wire

//--- design/store_align.sv
`timescale 1ns/1ns
`default_nettype none

module store_align import mem_pkg::*; (
    input  logic [31:0] write_data_i,
    input  width_src_e  width_src_i,
    input  logic [1:0]  byte_off_i,
    input  logic        mem_write_i,
    output logic [3:0]  byte_en_o,
    output mem_word_u   lane_data_o
);

    logic [3:0] lane_mask;

    always_comb begin
        case (width_src_i)
            width_8s, width_8u: begin
                // Low byte copied into every lane
                for (int i = 0; i < 4; i++) begin
                    lane_data_o.lanes[i] = write_data_i[7:0];
                end
                lane_mask = 4'b0001 << byte_off_i;
            end
            width_16s, width_16u: begin
                // Low halfword copied into both halves
                for (int i = 0; i < 4; i++) begin
                    lane_data_o.lanes[i] = write_data_i[8*(i%2) +: 8];
                end
                lane_mask = byte_off_i[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                lane_data_o = write_data_i;
                lane_mask   = 4'b1111;
            end
        endcase
    end

    // No lanes enabled unless this is a store
    assign byte_en_o = mem_write_i ? lane_mask : 4'b0000;

endmodule

`default_nettype wire

//--- design/data_mem.sv
`timescale 1ns/1ns
`default_nettype none

module data_mem import mem_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic        clk_i,
    input  logic [31:0] addr_i,
    input  logic [3:0]  byte_en_i,
    input  mem_word_u   lane_data_i,
    output mem_word_u   read_word_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    mem_word_u        mem [MEM_WORDS];
    logic [IDX_W-1:0] word_idx;

    // Word index wraps at the memory depth
    assign word_idx = addr_i[IDX_W+1:2];

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // Byte-enable write
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < 4; i++) begin
            if (byte_en_i[i]) begin
                mem[word_idx].lanes[i] <= lane_data_i.lanes[i];
            end
        end
    end

    assign read_word_o = mem[word_idx];

endmodule

`default_nettype wire

//--- design/writeback_stage.sv
`timescale 1ns/1ns
`default_nettype none

module writeback_stage import mem_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        stall_m_i,

    // Bundle from the memory stage
    input  mem_wb_t     wb_i,

    // Register file write port
    output logic [31:0] result_w_o,
    output logic [4:0]  rd_w_o,
    output logic        reg_write_w_o
);

    mem_wb_t wb_q;

    // Memory-to-writeback register, same enable as the memory stage
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_q <= '0;
        end else if (!stall_m_i) begin
            wb_q <= wb_i;
        end
    end

    // Loads take the reduced word, all else the forwarded value
    always_comb begin
        if (wb_q.result_src == result_mem) begin
            result_w_o = wb_q.reduced_data;
        end else begin
            result_w_o = wb_q.forward_data;
        end
    end

    assign rd_w_o        = wb_q.rd;
    assign reg_write_w_o = wb_q.reg_write;

endmodule

`default_nettype wire

//--- design/mem_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem import mem_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic        clk_i,
    input  logic        reset_i,
    input  ex_mem_t     ex_i,
    input  logic        stall_m_i,

    // To hazard and forwarding logic
    output logic [31:0] forward_data_m_o,
    output logic [4:0]  rd_m_o,
    output logic        reg_write_m_o,

    // To the register file
    output logic [31:0] result_w_o,
    output logic [4:0]  rd_w_o,
    output logic        reg_write_w_o
);

    ex_mem_t    mem_bundle;
    mem_wb_t    wb_bundle;
    mem_word_u  read_word;
    mem_word_u  lane_data;
    logic [3:0] byte_en;

    memory_stage memory_stage_inst (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .stall_m_i        (stall_m_i),
        .ex_i             (ex_i),
        .read_word_i      (read_word),
        .mem_o            (mem_bundle),
        .forward_data_m_o (forward_data_m_o),
        .wb_o             (wb_bundle)
    );

    assign rd_m_o        = mem_bundle.rd;
    assign reg_write_m_o = mem_bundle.reg_write;

    // Store data placed into its byte lanes
    store_align store_align_inst (
        .write_data_i (mem_bundle.write_data),
        .width_src_i  (mem_bundle.width_src),
        .byte_off_i   (mem_bundle.alu_result[1:0]),
        .mem_write_i  (mem_bundle.mem_write),
        .byte_en_o    (byte_en),
        .lane_data_o  (lane_data)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) data_mem_inst (
        .clk_i       (clk_i),
        .addr_i      (mem_bundle.alu_result),
        .byte_en_i   (byte_en),
        .lane_data_i (lane_data),
        .read_word_o (read_word)
    );

    writeback_stage writeback_stage_inst (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .stall_m_i     (stall_m_i),
        .wb_i          (wb_bundle),
        .result_w_o    (result_w_o),
        .rd_w_o        (rd_w_o),
        .reg_write_w_o (reg_write_w_o)
    );

endmodule

`default_nettype wire

//--- tests/mem_subsystem_sva.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_sva (
    input logic        clk_i,
    input logic        reset_i,
    input logic        stall_m_i,
    input logic        reg_write_i,
    input logic [4:0]  rd_i,
    input logic [31:0] data_i
);

    // Stage register comes out of reset empty
    assert property (@(posedge clk_i) reset_i |=> !reg_write_i && rd_i == 5'd0)
        else $error("stage not cleared in the cycle after reset");

    // Stalled stage keeps its outputs
    assert property (@(posedge clk_i) stall_m_i && !reset_i |=> $stable(rd_i) && $stable(reg_write_i))
        else $error("rd or reg_write changed during stall");

    assert property (@(posedge clk_i) stall_m_i && !reset_i |=> $stable(data_i))
        else $error("stage data changed during stall");

endmodule

bind memory_stage mem_subsystem_sva memory_stage_sva_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .stall_m_i   (stall_m_i),
    .reg_write_i (mem_o.reg_write),
    .rd_i        (mem_o.rd),
    .data_i      (forward_data_m_o)
);

bind writeback_stage mem_subsystem_sva writeback_stage_sva_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .stall_m_i   (stall_m_i),
    .reg_write_i (reg_write_w_o),
    .rd_i        (rd_w_o),
    .data_i      (result_w_o)
);

`default_nettype wire

//--- tests/mem_subsystem_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsystem_tb import mem_pkg::*; ();

    localparam int MEM_WORDS   = 256;
    localparam int CLK_PERIOD  = 8;
    localparam int N_ROUNDS    = 8;
    // Cycles of reset, store/load rounds, partial stores, forwarding and stall
    localparam int TEST_CYCLES = 5 + N_ROUNDS * 29 + 5 + 8 + 7;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 20) * CLK_PERIOD;

    logic        clk;
    logic        reset;
    logic        stall_m;
    ex_mem_t     ex;
    logic [31:0] forward_data_m;
    logic [4:0]  rd_m;
    logic        reg_write_m;
    logic [31:0] result_w;
    logic [4:0]  rd_w;
    logic        reg_write_w;

    // Byte image of the data memory
    logic [7:0]  ref_mem [MEM_WORDS*4];
    int          errors;
    int          seed = 32'hfb1b_a387;

    mem_subsystem #(
        .MEM_WORDS (MEM_WORDS)
    ) mem_subsystem_inst (
        .clk_i            (clk),
        .reset_i          (reset),
        .ex_i             (ex),
        .stall_m_i        (stall_m),
        .forward_data_m_o (forward_data_m),
        .rd_m_o           (rd_m),
        .reg_write_m_o    (reg_write_m),
        .result_w_o       (result_w),
        .rd_w_o           (rd_w),
        .reg_write_w_o    (reg_write_w)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h got %h", name, expected, actual);
            errors++;
        end
    endtask

    // Loaded value per the width and extension rules
    function automatic logic [31:0] expected_load(logic [31:0] addr, width_src_e width);
        int          idx;
        logic [7:0]  b;
        logic [15:0] h;
        idx = int'(addr % (MEM_WORDS * 4));
        b = ref_mem[idx];
        h = {ref_mem[idx + 1], ref_mem[idx]};
        case (width)
            width_8s:  return {{24{b[7]}}, b};
            width_8u:  return {24'h0, b};
            width_16s: return {{16{h[15]}}, h};
            width_16u: return {16'h0, h};
            default:   return {ref_mem[idx + 3], ref_mem[idx + 2], h};
        endcase
    endfunction

    function automatic void model_store(logic [31:0] addr, logic [31:0] data, width_src_e width);
        int idx;
        int n;
        idx = int'(addr % (MEM_WORDS * 4));
        n = (width == width_32) ? 4 : ((width == width_16s || width == width_16u) ? 2 : 1);
        for (int i = 0; i < n; i++) begin
            ref_mem[idx + i] = data[8*i +: 8];
        end
    endfunction

    task automatic store_data(logic [31:0] addr, logic [31:0] data, width_src_e width);
        ex = '0;
        ex.alu_result = addr;
        ex.write_data = data;
        ex.width_src  = width;
        ex.mem_write  = 1'b1;
        model_store(addr, data, width);
        @(negedge clk);
        ex = '0;
    endtask

    task automatic load_and_check(logic [31:0] addr, width_src_e width);
        logic [31:0] expected;
        expected = expected_load(addr, width);
        ex = '0;
        ex.alu_result = addr;
        ex.width_src  = width;
        ex.result_src = result_mem;
        ex.reg_write  = 1'b1;
        ex.rd         = 5'd10;
        @(negedge clk);
        ex = '0;
        @(negedge clk);
        check_value("result_w_o", expected, result_w);
        check_value("rd_w_o", 32'd10, 32'(rd_w));
        check_value("reg_write_w_o", 32'd1, 32'(reg_write_w));
    endtask

    task automatic check_reset();
        check_value("reg_write_m_o", 32'd0, 32'(reg_write_m));
        check_value("reg_write_w_o", 32'd0, 32'(reg_write_w));
        check_value("rd_m_o", 32'd0, 32'(rd_m));
        check_value("rd_w_o", 32'd0, 32'(rd_w));
    endtask

    // Word, halfword and byte stores followed by every load form
    task automatic test_store_load();
        logic [31:0] base;
        logic [31:0] rnd;
        for (int r = 0; r < N_ROUNDS; r++) begin
            rnd  = random_word();
            base = {rnd[31:2], 2'b00};
            store_data(base, random_word(), width_32);
            rnd = random_word();
            store_data(base + {30'b0, rnd[1], 1'b0}, random_word(), width_16u);
            store_data(base + {30'b0, rnd[4:3]}, random_word(), width_8s);
            load_and_check(base, width_32);
            for (int off = 0; off < 4; off++) begin
                load_and_check(base + off, width_8s);
                load_and_check(base + off, width_8u);
                if (off % 2 == 0) begin
                    load_and_check(base + off, width_16s);
                    load_and_check(base + off, width_16u);
                end
            end
        end
    endtask

    task automatic test_partial_stores();
        store_data(32'h0000_0040, 32'h8899_aabb, width_32);
        store_data(32'h0000_0041, 32'hffff_ff11, width_8u);
        store_data(32'h0000_0042, 32'hffff_2233, width_16s);
        load_and_check(32'h0000_0040, width_32);
    endtask

    task automatic test_forwarding();
        result_src_e srcs [4] = '{result_alu, result_pc_target, result_pc_plus4, result_imm_ext};
        logic [31:0] expected;
        for (int i = 0; i < 4; i++) begin
            ex = '0;
            ex.alu_result = random_word();
            ex.pc_target  = random_word();
            ex.pc_plus4   = random_word();
            ex.imm_ext    = random_word();
            ex.result_src = srcs[i];
            ex.reg_write  = 1'b1;
            ex.rd         = 5'(i + 1);
            case (i)
                0:       expected = ex.alu_result;
                1:       expected = ex.pc_target;
                2:       expected = ex.pc_plus4;
                default: expected = ex.imm_ext;
            endcase
            @(negedge clk);
            ex = '0;
            check_value("forward_data_m_o", expected, forward_data_m);
            check_value("rd_m_o", 32'(i + 1), 32'(rd_m));
            check_value("reg_write_m_o", 32'd1, 32'(reg_write_m));
            @(negedge clk);
            check_value("result_w_o", expected, result_w);
        end
    endtask

    task automatic test_stall();
        logic [31:0] held_value;
        logic [31:0] held_result;
        logic [4:0]  held_rd;
        ex = '0;
        ex.alu_result = random_word();
        ex.rd         = 5'd7;
        ex.reg_write  = 1'b1;
        held_value    = ex.alu_result;
        @(negedge clk);
        held_result = result_w;
        held_rd     = rd_w;
        // New bundle waits at the input while stalled
        stall_m       = 1'b1;
        ex.alu_result = ~held_value;
        ex.rd         = 5'd9;
        repeat (4) begin
            @(negedge clk);
            check_value("forward_data_m_o", held_value, forward_data_m);
            check_value("rd_m_o", 32'd7, 32'(rd_m));
            check_value("result_w_o", held_result, result_w);
            check_value("rd_w_o", 32'(held_rd), 32'(rd_w));
        end
        stall_m = 1'b0;
        @(negedge clk);
        ex = '0;
        check_value("forward_data_m_o", ~held_value, forward_data_m);
        check_value("rd_m_o", 32'd9, 32'(rd_m));
        check_value("result_w_o", held_value, result_w);
        @(negedge clk);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        stall_m = 1'b0;
        errors  = 0;
        // Busy bundle held at the input during reset
        ex           = '0;
        ex.reg_write = 1'b1;
        ex.rd        = 5'd31;
        for (int i = 0; i < MEM_WORDS * 4; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (5) @(negedge clk);
        check_reset();
        reset = 1'b0;
        ex    = '0;
        test_store_load();
        test_partial_stores();
        test_forwarding();
        test_stall();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mem_subsystem.f
design/mem_pkg.sv
design/load_reduce.sv
design/memory_stage.sv
design/store_align.sv
design/data_mem.sv
design/writeback_stage.sv
design/mem_subsystem.sv
tests/mem_subsystem_sva.sv
tests/mem_subsystem_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mem_subsystem_tb -f mem_subsystem.f
out=$(./obj_dir/Vmem_subsystem_tb)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
else
    exit 1
fi
